//--- Bender.yml
package:
  name: dbg_mem

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/dbg_mem_pkg.sv
      - source/hart_bus_decode.sv
      - source/hart_flags.sv
      - source/abstract_cmd_gen.sv
      - source/cmd_fsm.sv
      - source/dbg_rdata_mux.sv
      - source/dbg_mem_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verif/tb_dbg_mem.sv

//--- include/dbg_mem_consts.svh
// Debug memory constants

`ifndef DBG_MEM_CONSTS_SVH
`define DBG_MEM_CONSTS_SVH

// decoded width of the hart bus address
`define DBG_ADDR_BITS 12

// --------------------------------------------------
// event write addresses
// --------------------------------------------------
`define DBG_HALTED    12'h100
`define DBG_GOING     12'h104
`define DBG_RESUMING  12'h108
`define DBG_EXCEPTION 12'h10C

// --------------------------------------------------
// memory map
// --------------------------------------------------
// jump slot fetched by the hart
`define DBG_WHERETO     12'h300
// eight abstract command words, up to 0x37F
`define DBG_ABSCMD_BASE 12'h360
`define DBG_DATA_BASE   12'h380
`define DBG_DATA_COUNT  2
// one flag byte per hart
`define DBG_FLAGS_BASE  12'h400
`define DBG_FLAGS_END   12'h7FF

`define DBG_RESUME_ADDR 12'h808

`define DBG_NR_HARTS_DEFAULT 4

`endif

//--- project.f
+incdir+include
source/dbg_mem_pkg.sv
source/hart_bus_decode.sv
source/hart_flags.sv
source/abstract_cmd_gen.sv
source/cmd_fsm.sv
source/dbg_rdata_mux.sv
source/dbg_mem_top.sv
verif/tb_dbg_mem.sv

//--- source/abstract_cmd_gen.sv
// Abstract command generator

`timescale 1ns/1ns
`default_nettype none

`include "dbg_mem_consts.svh"

module abstract_cmd_gen (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic [7:0]       cmd_type_i,
    input  logic [23:0]      cmd_control_i,
    input  logic             accept_i,
    output logic             supported_o,
    output logic [7:0][31:0] abscmd_o
);

    import dbg_mem_pkg::*;

    localparam logic [11:0] CsrDscratch1 = 12'h7B3;
    localparam logic [4:0]  RegA0        = 5'd10;
    localparam logic [31:0] Nop          = {12'h000, 5'd0, 3'b000, 5'd0, OPC_OP_IMM};

    logic       transfer_q, write_q;
    logic [4:0] regno_q;
    logic       regno_ok;

    function automatic logic [31:0] itype(input logic [11:0] imm, input logic [4:0] rs1,
                                          input logic [2:0] f3, input logic [4:0] rd,
                                          input rv_opcode_e opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] stype(input logic [11:0] imm, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input rv_opcode_e opc);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], opc};
    endfunction

    // gpr range 0x1000..0x101f
    assign regno_ok = (cmd_control_i[15:5] == 11'h080);

    // only 32 bit register access with an optional transfer
    assign supported_o = (cmd_type_i == ACCESS_REGISTER) &&
                         (cmd_control_i[22:20] == 3'd2) &&
                         (!cmd_control_i[17] || regno_ok);

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            transfer_q <= 1'b0;
            write_q    <= 1'b0;
            regno_q    <= 5'd0;
        end else if (accept_i) begin
            transfer_q <= cmd_control_i[17];
            write_q    <= cmd_control_i[16];
            regno_q    <= cmd_control_i[4:0];
        end
    end

    // --------------------------------------------------
    // command words
    // --------------------------------------------------
    always_comb begin
        // save a0, then point it at the debug module base
        abscmd_o[0] = itype(CsrDscratch1, RegA0, 3'b001, 5'd0, OPC_SYSTEM);
        abscmd_o[1] = {20'h00000, RegA0, OPC_AUIPC};
        abscmd_o[2] = itype({7'b0, 5'd12}, RegA0, 3'b101, RegA0, OPC_OP_IMM);
        abscmd_o[3] = itype({7'b0, 5'd12}, RegA0, 3'b001, RegA0, OPC_OP_IMM);
        abscmd_o[4] = Nop;
        if (transfer_q) begin
            if (write_q) begin
                abscmd_o[4] = itype(`DBG_DATA_BASE, RegA0, 3'b010, regno_q, OPC_LOAD);
            end else begin
                abscmd_o[4] = stype(`DBG_DATA_BASE, regno_q, RegA0, 3'b010, OPC_STORE);
            end
        end
        abscmd_o[5] = Nop;
        // restore a0 and return to the park loop
        abscmd_o[6] = itype(CsrDscratch1, 5'd0, 3'b010, RegA0, OPC_SYSTEM);
        abscmd_o[7] = itype(12'h001, 5'd0, 3'b000, 5'd0, OPC_SYSTEM);
    end

endmodule

`default_nettype wire

//--- source/cmd_fsm.sv
// Command state machine

`timescale 1ns/1ns
`default_nettype none

module cmd_fsm #(
    parameter int  NrHarts    = 4,
    localparam int HartSelLen = (NrHarts > 1) ? $clog2(NrHarts) : 1
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  cmd_valid_i,
    input  logic                  supported_i,
    input  logic [HartSelLen-1:0] hartsel_i,
    input  logic [NrHarts-1:0]    halted_i,
    input  logic [NrHarts-1:0]    resuming_i,
    input  logic [NrHarts-1:0]    haltreq_i,
    input  logic                  resumereq_i,
    input  logic                  going_stb_i,
    input  logic                  halted_stb_i,
    input  logic                  exception_stb_i,
    output logic                  accept_o,
    output logic                  go_o,
    output logic                  resume_o,
    output logic                  cmdbusy_o,
    output logic                  cmderror_valid_o,
    output dbg_mem_pkg::cmderr_e  cmderror_o
);

    import dbg_mem_pkg::*;

    cmd_state_e state_d, state_q;
    logic       sel_halted;

    assign sel_halted = halted_i[hartsel_i];
    assign accept_o   = (state_q == IDLE) && cmd_valid_i && sel_halted && supported_i;
    assign go_o       = (state_q == GO);
    assign resume_o   = (state_q == RESUME);
    assign cmdbusy_o  = (state_q != IDLE);

    always_comb begin
        state_d          = state_q;
        cmderror_valid_o = 1'b0;
        cmderror_o       = CMDERR_NONE;
        case (state_q)
            IDLE: begin
                if (accept_o) begin
                    state_d = GO;
                end else if (cmd_valid_i) begin
                    // single pulse, the command is dropped
                    cmderror_valid_o = 1'b1;
                    cmderror_o       = sel_halted ? CMDERR_NOT_SUPPORTED : CMDERR_HALT_RESUME;
                end else if (resumereq_i && !resuming_i[hartsel_i] &&
                             !haltreq_i[hartsel_i] && sel_halted) begin
                    state_d = RESUME;
                end
            end
            GO:            if (going_stb_i) state_d = CMD_EXECUTING;
            CMD_EXECUTING: if (halted_stb_i) state_d = IDLE;
            RESUME:        if (resuming_i[hartsel_i]) state_d = IDLE;
            default:       state_d = IDLE;
        endcase
        if (exception_stb_i) begin
            cmderror_valid_o = 1'b1;
            cmderror_o       = CMDERR_EXCEPTION;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

`default_nettype wire

//--- source/dbg_mem_pkg.sv
// Debug memory types

`default_nettype none

package dbg_mem_pkg;

    // command and resume sequencing
    typedef enum logic [1:0] {
        IDLE,
        GO,
        RESUME,
        CMD_EXECUTING
    } cmd_state_e;

    typedef enum logic [2:0] {
        CMDERR_NONE          = 3'd0,
        CMDERR_BUSY          = 3'd1,
        CMDERR_NOT_SUPPORTED = 3'd2,
        CMDERR_EXCEPTION     = 3'd3,
        CMDERR_HALT_RESUME   = 3'd4
    } cmderr_e;

    // abstract command types, only access register is executed
    typedef enum logic [7:0] {
        ACCESS_REGISTER = 8'd0,
        QUICK_ACCESS    = 8'd1,
        ACCESS_MEMORY   = 8'd2
    } cmdtype_e;

    // base opcodes used to build the command words
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'h03,
        OPC_OP_IMM = 7'h13,
        OPC_AUIPC  = 7'h17,
        OPC_STORE  = 7'h23,
        OPC_JAL    = 7'h6F,
        OPC_SYSTEM = 7'h73
    } rv_opcode_e;

    // which region the last hart read addressed
    typedef enum logic [2:0] {
        RD_NONE,
        RD_WHERETO,
        RD_DATA,
        RD_ABSCMD,
        RD_FLAGS
    } rd_src_e;

endpackage

`default_nettype wire

//--- source/dbg_mem_top.sv
// Debug memory top level

`timescale 1ns/1ns
`default_nettype none

`include "dbg_mem_consts.svh"

module dbg_mem_top #(
    parameter int  NrHarts    = `DBG_NR_HARTS_DEFAULT,
    localparam int HartSelLen = (NrHarts > 1) ? $clog2(NrHarts) : 1
) (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    // hart bus
    input  logic                             req_i,
    input  logic                             we_i,
    input  logic [31:0]                      addr_i,
    input  logic [31:0]                      wdata_i,
    input  logic [3:0]                       be_i,
    output logic [31:0]                      rdata_o,
    // debugger side
    input  logic [HartSelLen-1:0]            hartsel_i,
    input  logic [NrHarts-1:0]               haltreq_i,
    input  logic                             resumereq_i,
    output logic [NrHarts-1:0]               debug_req_o,
    output logic [NrHarts-1:0]               halted_o,
    output logic [NrHarts-1:0]               resuming_o,
    input  logic                             cmd_valid_i,
    input  logic [7:0]                       cmd_type_i,
    input  logic [23:0]                      cmd_control_i,
    output logic                             cmdbusy_o,
    output logic                             cmderror_valid_o,
    output dbg_mem_pkg::cmderr_e             cmderror_o,
    input  logic [`DBG_DATA_COUNT-1:0][31:0] data_i,
    output logic [`DBG_DATA_COUNT-1:0][31:0] data_o,
    output logic                             data_valid_o
);

    import dbg_mem_pkg::*;

    logic                  halted_stb, going_stb, resuming_stb, exception_stb;
    logic [HartSelLen-1:0] ev_hart;
    rd_src_e               rd_src;
    logic [2:0]            rd_index;
    logic [NrHarts*8-1:0]  flag_bytes;
    logic [7:0][31:0]      abscmd;
    logic                  accept, supported, go, resume;

    // halt requests go straight to the harts
    assign debug_req_o = haltreq_i;

    hart_bus_decode #(.NrHarts(NrHarts)) u_decode (
        .clk_i, .rst_ni, .req_i, .we_i, .addr_i, .wdata_i, .be_i, .data_i,
        .halted_stb_o    (halted_stb),
        .going_stb_o     (going_stb),
        .resuming_stb_o  (resuming_stb),
        .exception_stb_o (exception_stb),
        .ev_hart_o       (ev_hart),
        .data_o, .data_valid_o,
        .rd_src_o        (rd_src),
        .rd_index_o      (rd_index)
    );

    for (genvar h = 0; h < NrHarts; h++) begin : gen_hart
        hart_flags #(.NrHarts(NrHarts), .HartIndex(h)) u_flags (
            .clk_i, .rst_ni,
            .halted_stb_i   (halted_stb),
            .resuming_stb_i (resuming_stb),
            .ev_hart_i      (ev_hart),
            .clr_resuming_i (!resumereq_i),
            .sel_i          (hartsel_i),
            .go_i           (go),
            .resume_i       (resume),
            .halted_o       (halted_o[h]),
            .resuming_o     (resuming_o[h]),
            .flag_byte_o    (flag_bytes[h*8 +: 8])
        );
    end

    abstract_cmd_gen u_cmd_gen (
        .clk_i, .rst_ni, .cmd_type_i, .cmd_control_i,
        .accept_i    (accept),
        .supported_o (supported),
        .abscmd_o    (abscmd)
    );

    cmd_fsm #(.NrHarts(NrHarts)) u_fsm (
        .clk_i, .rst_ni, .cmd_valid_i, .hartsel_i, .haltreq_i, .resumereq_i,
        .supported_i     (supported),
        .halted_i        (halted_o),
        .resuming_i      (resuming_o),
        .going_stb_i     (going_stb),
        .halted_stb_i    (halted_stb),
        .exception_stb_i (exception_stb),
        .accept_o        (accept),
        .go_o            (go),
        .resume_o        (resume),
        .cmdbusy_o, .cmderror_valid_o, .cmderror_o
    );

    dbg_rdata_mux #(.NrHarts(NrHarts)) u_rdata (
        .clk_i, .rst_ni, .data_i, .resumereq_i, .rdata_o,
        .rd_src_i     (rd_src),
        .rd_index_i   (rd_index),
        .abscmd_i     (abscmd),
        .flag_bytes_i (flag_bytes),
        .cmdbusy_i    (cmdbusy_o)
    );

endmodule

`default_nettype wire

//--- source/dbg_rdata_mux.sv
// Hart read data mux

`timescale 1ns/1ns
`default_nettype none

`include "dbg_mem_consts.svh"

module dbg_rdata_mux #(
    parameter int NrHarts = `DBG_NR_HARTS_DEFAULT
) (
    input  logic                             clk_i,
    input  logic                             rst_ni,
    input  dbg_mem_pkg::rd_src_e             rd_src_i,
    input  logic [2:0]                       rd_index_i,
    input  logic [`DBG_DATA_COUNT-1:0][31:0] data_i,
    input  logic [7:0][31:0]                 abscmd_i,
    input  logic [NrHarts*8-1:0]             flag_bytes_i,
    input  logic                             cmdbusy_i,
    input  logic                             resumereq_i,
    output logic [31:0]                      rdata_o
);

    import dbg_mem_pkg::*;

    // jump offsets relative to the whereto slot
    localparam logic [20:0] AbsCmdOff = 21'(`DBG_ABSCMD_BASE - `DBG_WHERETO);
    localparam logic [20:0] ResumeOff = 21'(`DBG_RESUME_ADDR - `DBG_WHERETO);

    logic [31:0] rdata_q;

    function automatic logic [31:0] jal_x0(input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'd0, OPC_JAL};
    endfunction

    always_comb begin
        int h;
        h       = 0;
        rdata_o = 32'h0;
        case (rd_src_i)
            RD_WHERETO: begin
                // a running command takes precedence over resume
                if (cmdbusy_i) begin
                    rdata_o = jal_x0(AbsCmdOff);
                end else if (resumereq_i) begin
                    rdata_o = jal_x0(ResumeOff);
                end else begin
                    rdata_o = rdata_q;
                end
            end
            RD_DATA:   rdata_o = data_i[rd_index_i];
            RD_ABSCMD: rdata_o = abscmd_i[rd_index_i];
            RD_FLAGS: begin
                // four hart bytes per word
                for (int b = 0; b < 4; b++) begin
                    h = int'(rd_index_i) * 4 + b;
                    if (h < NrHarts) begin
                        rdata_o[b*8 +: 8] = flag_bytes_i[h*8 +: 8];
                    end
                end
            end
            default: rdata_o = 32'h0;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rdata_q <= 32'h0;
        end else begin
            rdata_q <= rdata_o;
        end
    end

endmodule

`default_nettype wire

//--- source/hart_bus_decode.sv
// Hart bus decoder

`timescale 1ns/1ns
`default_nettype none

`include "dbg_mem_consts.svh"

module hart_bus_decode #(
    parameter int   NrHarts    = `DBG_NR_HARTS_DEFAULT,
    localparam int  HartSelLen = (NrHarts > 1) ? $clog2(NrHarts) : 1
) (
    input  logic                                clk_i,
    input  logic                                rst_ni,
    input  logic                                req_i,
    input  logic                                we_i,
    input  logic [31:0]                         addr_i,
    input  logic [31:0]                         wdata_i,
    input  logic [3:0]                          be_i,
    input  logic [`DBG_DATA_COUNT-1:0][31:0]    data_i,
    output logic                                halted_stb_o,
    output logic                                going_stb_o,
    output logic                                resuming_stb_o,
    output logic                                exception_stb_o,
    output logic [HartSelLen-1:0]               ev_hart_o,
    output logic [`DBG_DATA_COUNT-1:0][31:0]    data_o,
    output logic                                data_valid_o,
    output dbg_mem_pkg::rd_src_e                rd_src_o,
    output logic [2:0]                          rd_index_o
);

    import dbg_mem_pkg::*;

    localparam logic [11:0] DataEnd   = `DBG_DATA_BASE + 4 * `DBG_DATA_COUNT - 1;
    localparam logic [11:0] AbsCmdEnd = `DBG_ABSCMD_BASE + 12'h1F;

    logic [`DBG_ADDR_BITS-1:0] addr;
    logic [11:0] data_off, abs_off, flag_off;
    logic        wr, in_data, in_abscmd, in_flags;
    rd_src_e     rd_src_d;
    logic [2:0]  rd_index_d;

    assign addr      = addr_i[`DBG_ADDR_BITS-1:0];
    assign wr        = req_i & we_i;
    assign data_off  = addr - `DBG_DATA_BASE;
    assign abs_off   = addr - `DBG_ABSCMD_BASE;
    assign flag_off  = addr - `DBG_FLAGS_BASE;
    assign in_data   = (addr >= `DBG_DATA_BASE) && (addr <= DataEnd);
    assign in_abscmd = (addr >= `DBG_ABSCMD_BASE) && (addr <= AbsCmdEnd);
    assign in_flags  = (addr >= `DBG_FLAGS_BASE) && (addr <= `DBG_FLAGS_END);

    // event strobes, the hart reports its own index in the write data
    assign halted_stb_o    = wr && (addr == `DBG_HALTED);
    assign going_stb_o     = wr && (addr == `DBG_GOING);
    assign resuming_stb_o  = wr && (addr == `DBG_RESUMING);
    assign exception_stb_o = wr && (addr == `DBG_EXCEPTION);
    assign ev_hart_o       = wdata_i[HartSelLen-1:0];
    assign data_valid_o    = wr && in_data;

    // byte enabled merge into the addressed data word
    always_comb begin
        data_o = data_i;
        if (data_valid_o) begin
            for (int b = 0; b < 4; b++) begin
                if (be_i[b]) begin
                    data_o[data_off[4:2]][b*8 +: 8] = wdata_i[b*8 +: 8];
                end
            end
        end
    end

    always_comb begin
        rd_src_d   = RD_NONE;
        rd_index_d = 3'd0;
        if (addr == `DBG_WHERETO) begin
            rd_src_d = RD_WHERETO;
        end else if (in_data) begin
            rd_src_d   = RD_DATA;
            rd_index_d = data_off[4:2];
        end else if (in_abscmd) begin
            rd_src_d   = RD_ABSCMD;
            rd_index_d = abs_off[4:2];
        end else if (in_flags) begin
            rd_src_d   = RD_FLAGS;
            rd_index_d = flag_off[4:2];
        end
    end

    // selection is kept until the next read
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_src_o   <= RD_NONE;
            rd_index_o <= 3'd0;
        end else if (req_i && !we_i) begin
            rd_src_o   <= rd_src_d;
            rd_index_o <= rd_index_d;
        end
    end

endmodule

`default_nettype wire

//--- source/hart_flags.sv
// Per-hart status flags

`timescale 1ns/1ns
`default_nettype none

module hart_flags #(
    parameter int  NrHarts    = 4,
    parameter int  HartIndex  = 0,
    localparam int HartSelLen = (NrHarts > 1) ? $clog2(NrHarts) : 1
) (
    input  logic                  clk_i,
    input  logic                  rst_ni,
    input  logic                  halted_stb_i,
    input  logic                  resuming_stb_i,
    input  logic [HartSelLen-1:0] ev_hart_i,
    input  logic                  clr_resuming_i,
    input  logic [HartSelLen-1:0] sel_i,
    input  logic                  go_i,
    input  logic                  resume_i,
    output logic                  halted_o,
    output logic                  resuming_o,
    output logic [7:0]            flag_byte_o
);

    logic ev_match, selected;

    assign ev_match = (ev_hart_i == HartSelLen'(HartIndex));
    assign selected = (sel_i == HartSelLen'(HartIndex));

    // go and resume are only shown to the selected hart
    assign flag_byte_o = selected ? {6'b0, resume_i, go_i} : 8'h00;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            halted_o   <= 1'b0;
            resuming_o <= 1'b0;
        end else begin
            if (halted_stb_i && ev_match) begin
                halted_o <= 1'b1;
            end
            // a resuming write wins over the clear from the debugger
            if (resuming_stb_i && ev_match) begin
                halted_o   <= 1'b0;
                resuming_o <= 1'b1;
            end else if (clr_resuming_i && selected) begin
                resuming_o <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- verif/tb_dbg_mem.sv
// Debug memory testbench

`timescale 1ns/1ns
`default_nettype none

`include "dbg_mem_consts.svh"

module tb_dbg_mem;

    import dbg_mem_pkg::*;

    localparam int NrHarts = 4;

    // jal x0 from the whereto slot to 0x360 and to 0x808
    localparam logic [31:0] JalAbsCmd = 32'h0600_006F;
    localparam logic [31:0] JalResume = 32'h5080_006F;
    localparam logic [31:0] Nop       = 32'h0000_0013;

    logic                clk_i;
    logic                rst_ni;
    logic                req_i;
    logic                we_i;
    logic [31:0]         addr_i;
    logic [31:0]         wdata_i;
    logic [3:0]          be_i;
    logic [31:0]         rdata_o;
    logic [1:0]          hartsel_i;
    logic [NrHarts-1:0]  haltreq_i;
    logic                resumereq_i;
    logic [NrHarts-1:0]  debug_req_o;
    logic [NrHarts-1:0]  halted_o;
    logic [NrHarts-1:0]  resuming_o;
    logic                cmd_valid_i;
    logic [7:0]          cmd_type_i;
    logic [23:0]         cmd_control_i;
    logic                cmdbusy_o;
    logic                cmderror_valid_o;
    cmderr_e             cmderror_o;
    logic [1:0][31:0]    data_i;
    logic [1:0][31:0]    data_o;
    logic                data_valid_o;

    // reference model of the hart status bits
    logic [NrHarts-1:0]  model_halted;
    logic [NrHarts-1:0]  model_resuming;

    integer seed;
    int     errors;
    int     checks;
    int     tests;

    dbg_mem_top #(.NrHarts(NrHarts)) uut (
        .clk_i, .rst_ni, .req_i, .we_i, .addr_i, .wdata_i, .be_i, .rdata_o,
        .hartsel_i, .haltreq_i, .resumereq_i, .debug_req_o, .halted_o, .resuming_o,
        .cmd_valid_i, .cmd_type_i, .cmd_control_i, .cmdbusy_o, .cmderror_valid_o,
        .cmderror_o, .data_i, .data_o, .data_valid_o
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------
    task automatic next_cycle();
        @(posedge clk_i);
        #1;
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[ERROR] t=%0t %s: got 0x%08h, expected 0x%08h", $time, name, got, exp);
        end
    endtask

    task automatic release_bus();
        req_i = 1'b0;
        we_i  = 1'b0;
    endtask

    task automatic drive_write(input logic [31:0] addr, input logic [31:0] data,
                               input logic [3:0] be);
        req_i   = 1'b1;
        we_i    = 1'b1;
        addr_i  = addr;
        wdata_i = data;
        be_i    = be;
    endtask

    task automatic hart_write(input logic [31:0] addr, input logic [31:0] data);
        drive_write(addr, data, 4'hF);
        next_cycle();
        release_bus();
    endtask

    // read data is valid once the selection has been registered
    task automatic hart_read(input logic [31:0] addr, output logic [31:0] data);
        req_i  = 1'b1;
        we_i   = 1'b0;
        addr_i = addr;
        be_i   = 4'hF;
        next_cycle();
        release_bus();
        data = rdata_o;
    endtask

    task automatic issue_cmd(input logic [7:0] ctype, input logic [23:0] ctrl,
                             output logic err_valid, output logic [2:0] err);
        cmd_valid_i   = 1'b1;
        cmd_type_i    = ctype;
        cmd_control_i = ctrl;
        #4;
        err_valid = cmderror_valid_o;
        err       = cmderror_o;
        next_cycle();
        cmd_valid_i = 1'b0;
    endtask

    task automatic wait_busy(input logic level, input int limit);
        int n;
        n = 0;
        while (cmdbusy_o !== level && n < limit) begin
            next_cycle();
            n++;
        end
        checks++;
        assert (cmdbusy_o === level) else begin
            errors++;
            $display("timeout: cmdbusy_o did not reach %0b within %0d cycles", level, limit);
        end
    endtask

    task automatic report_test(input string name, input int start_errors);
        tests++;
        $display("test %0d %-22s %0d error(s)", tests, name, errors - start_errors);
    endtask

    // RV32 encodings of the abstract command words
    function automatic logic [31:0] expected_abscmd(input int idx, input logic xfer,
                                                    input logic wr, input logic [4:0] rd);
        logic [31:0] w;
        w = Nop;
        case (idx)
            0: w = 32'h7B35_1073;
            1: w = 32'h0000_0517;
            2: w = 32'h00C5_5513;
            3: w = 32'h00C5_1513;
            4: begin
                // lw or sw of x[rd] at 0x380(a0)
                if (xfer && wr) begin
                    w = 32'h3805_2003 | (32'(rd) << 7);
                end else if (xfer) begin
                    w = 32'h3805_2023 | (32'(rd) << 20);
                end
            end
            6: w = 32'h7B30_2573;
            7: w = 32'h0010_0073;
            default: w = Nop;
        endcase
        return w;
    endfunction

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------
    initial begin
        logic [31:0]        r;
        logic [31:0]        rd_data;
        logic [31:0]        wd;
        logic [3:0]         be;
        logic [15:0]        regno;
        logic [23:0]        ctrl;
        logic [1:0][31:0]   exp_data;
        logic [NrHarts-1:0] hr;
        logic               wr_bit;
        logic               ev;
        logic [2:0]         ecode;
        int                 ha, hb, hn, w, start;

        seed   = 32'h4008;
        errors = 0;
        checks = 0;
        tests  = 0;
        rst_ni = 1'b0;
        req_i  = 1'b0;
        we_i   = 1'b0;
        addr_i = 32'h0;
        wdata_i = 32'h0;
        be_i   = 4'h0;
        hartsel_i = 2'd0;
        haltreq_i = '0;
        resumereq_i = 1'b0;
        cmd_valid_i = 1'b0;
        cmd_type_i = 8'h0;
        cmd_control_i = 24'h0;
        data_i = '0;
        model_halted = '0;
        model_resuming = '0;

        repeat (3) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;

        start = errors;
        check_value("cmdbusy_o", cmdbusy_o, 0);
        check_value("cmderror_valid_o", cmderror_valid_o, 0);
        check_value("data_valid_o", data_valid_o, 0);
        check_value("halted_o", halted_o, 0);
        check_value("resuming_o", resuming_o, 0);
        check_value("rdata_o", rdata_o, 0);
        report_test("reset values", start);

        // halt a random hart
        start = errors;
        r = $random(seed);
        ha = int'(r[1:0]);
        hartsel_i = 2'(ha);
        hart_write(32'(`DBG_HALTED), 32'(ha));
        model_halted[ha] = 1'b1;
        check_value("halted_o", halted_o, model_halted);
        hart_read(32'(`DBG_FLAGS_BASE) + 32'(ha), rd_data);
        check_value("rdata_o flags", rd_data, 32'h0);
        report_test("halt handshake", start);

        // command to a running hart
        start = errors;
        r = $random(seed);
        hn = (ha + 1 + int'(r[7:0] % 3)) % NrHarts;
        hartsel_i = 2'(hn);
        issue_cmd(ACCESS_REGISTER, {1'b0, 3'd2, 20'h0}, ev, ecode);
        check_value("cmderror_valid_o", ev, 1);
        check_value("cmderror_o", ecode, CMDERR_HALT_RESUME);
        repeat (3) begin
            next_cycle();
            check_value("cmdbusy_o", cmdbusy_o, 0);
        end
        report_test("command without halt", start);

        // register access on the halted hart
        start = errors;
        r = $random(seed);
        regno = 16'h1000 | 16'(r[4:0]);
        wr_bit = r[8];
        ctrl = {1'b0, 3'd2, 2'b00, 1'b1, wr_bit, regno};
        hartsel_i = 2'(ha);
        issue_cmd(ACCESS_REGISTER, ctrl, ev, ecode);
        check_value("cmderror_valid_o", ev, 0);
        wait_busy(1'b1, 10);
        hart_read(32'(`DBG_FLAGS_BASE) + 32'(ha), rd_data);
        check_value("rdata_o flags", rd_data, 32'h1 << (8 * ha));
        hart_read(32'(`DBG_WHERETO), rd_data);
        check_value("rdata_o whereto", rd_data, JalAbsCmd);
        for (int i = 0; i < 8; i++) begin
            hart_read(32'(`DBG_ABSCMD_BASE) + 32'(4 * i), rd_data);
            check_value($sformatf("rdata_o abscmd[%0d]", i), rd_data,
                        expected_abscmd(i, 1'b1, wr_bit, regno[4:0]));
        end
        hart_write(32'(`DBG_GOING), 32'(ha));
        hart_write(32'(`DBG_HALTED), 32'(ha));
        wait_busy(1'b0, 10);
        check_value("halted_o", halted_o, model_halted);
        report_test("full command", start);

        // byte enabled data write and read back
        start = errors;
        data_i[0] = $random(seed);
        data_i[1] = $random(seed);
        r = $random(seed);
        w = int'(r[0]);
        be = r[7:4];
        wd = $random(seed);
        exp_data = data_i;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                exp_data[w][b*8 +: 8] = wd[b*8 +: 8];
            end
        end
        drive_write(32'(`DBG_DATA_BASE) + 32'(4 * w), wd, be);
        #4;
        check_value("data_valid_o", data_valid_o, 1);
        check_value("data_o[0]", data_o[0], exp_data[0]);
        check_value("data_o[1]", data_o[1], exp_data[1]);
        next_cycle();
        release_bus();
        #4;
        check_value("data_valid_o", data_valid_o, 0);
        hart_read(32'(`DBG_DATA_BASE), rd_data);
        check_value("rdata_o data[0]", rd_data, data_i[0]);
        hart_read(32'(`DBG_DATA_BASE) + 32'd4, rd_data);
        check_value("rdata_o data[1]", rd_data, data_i[1]);
        report_test("data registers", start);

        // resume the halted hart, first held back by a halt request
        start = errors;
        r = $random(seed);
        hr = NrHarts'(r) | (NrHarts'(1) << ha);
        haltreq_i = hr;
        resumereq_i = 1'b1;
        next_cycle();
        check_value("debug_req_o", debug_req_o, hr);
        next_cycle();
        check_value("cmdbusy_o", cmdbusy_o, 0);
        haltreq_i = '0;
        wait_busy(1'b1, 10);
        hart_read(32'(`DBG_FLAGS_BASE) + 32'(ha), rd_data);
        check_value("rdata_o flags", rd_data, 32'h2 << (8 * ha));
        hart_write(32'(`DBG_RESUMING), 32'(ha));
        model_halted[ha]   = 1'b0;
        model_resuming[ha] = 1'b1;
        wait_busy(1'b0, 10);
        check_value("halted_o", halted_o, model_halted);
        check_value("resuming_o", resuming_o, model_resuming);
        hart_read(32'(`DBG_WHERETO), rd_data);
        check_value("rdata_o whereto", rd_data, JalResume);
        resumereq_i = 1'b0;
        next_cycle();
        model_resuming[ha] = 1'b0;
        check_value("resuming_o", resuming_o, model_resuming);
        report_test("resume", start);

        // rejected commands and a hart exception
        start = errors;
        r = $random(seed);
        hb = int'(r[1:0]);
        hart_write(32'(`DBG_HALTED), 32'(hb));
        model_halted[hb] = 1'b1;
        hartsel_i = 2'(hb);
        issue_cmd(ACCESS_MEMORY, {1'b0, 3'd2, 20'h0}, ev, ecode);
        check_value("cmderror_valid_o", ev, 1);
        check_value("cmderror_o", ecode, CMDERR_NOT_SUPPORTED);
        issue_cmd(ACCESS_REGISTER, {1'b0, 3'd3, 2'b00, 1'b1, 1'b0, 16'h1000 | 16'(r[12:8])},
                  ev, ecode);
        check_value("cmderror_valid_o", ev, 1);
        check_value("cmderror_o", ecode, CMDERR_NOT_SUPPORTED);
        check_value("cmdbusy_o", cmdbusy_o, 0);
        issue_cmd(ACCESS_REGISTER, {1'b0, 3'd2, 20'h0}, ev, ecode);
        check_value("cmderror_valid_o", ev, 0);
        wait_busy(1'b1, 10);
        hart_write(32'(`DBG_GOING), 32'(hb));
        drive_write(32'(`DBG_EXCEPTION), 32'(hb), 4'hF);
        #4;
        check_value("cmderror_valid_o", cmderror_valid_o, 1);
        check_value("cmderror_o", cmderror_o, CMDERR_EXCEPTION);
        next_cycle();
        release_bus();
        hart_write(32'(`DBG_HALTED), 32'(hb));
        wait_busy(1'b0, 10);
        check_value("halted_o", halted_o, model_halted);
        report_test("unsupported and exception", start);

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
